/* cart_settings.svh */
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// Mapper codes
`define MAPPER_LOROM    3'd0
`define MAPPER_HIROM    3'd1
`define MAPPER_EXHIROM  3'd2
`define MAPPER_MAP3     3'd3
`define MAPPER_SDD1     3'd4
`define MAPPER_MAP6     3'd6
`define MAPPER_MAP7     3'd7

// Feature word bit positions
`define FEAT_ST0010     1
`define FEAT_MSU1       3
`define FEAT_213F       4

// Config register selectors
`define CFG_MAPPER      4'd0
`define CFG_FEAT_LO     4'd1
`define CFG_FEAT_HI     4'd2
`define CFG_ROMMASK_0   4'd3
`define CFG_ROMMASK_1   4'd4
`define CFG_ROMMASK_2   4'd5
`define CFG_SRAMMASK_0  4'd6
`define CFG_SRAMMASK_1  4'd7
`define CFG_SRAMMASK_2  4'd8

`define SAVERAM_BASE    24'hE00000
`define MSU_BASE        16'h2000

// MSU-1 register offsets
`define MSU_OFS_SEEK_0  3'd0
`define MSU_OFS_SEEK_1  3'd1
`define MSU_OFS_SEEK_2  3'd2
`define MSU_OFS_SEEK_3  3'd3
`define MSU_OFS_TRK_LO  3'd4
`define MSU_OFS_TRK_HI  3'd5
`define MSU_OFS_VOLUME  3'd6
`define MSU_OFS_CTRL    3'd7

`endif

/* cart_pkg.sv */
package cart_pkg;

  // In-bank view of a console address, LoROM style
  typedef struct packed {
    logic [7:0]  bank;
    logic        a15;
    logic [14:0] offset;
  } snes_banked_t;

  // One bus word, read flat or split by bank
  typedef union packed {
    logic [23:0]  flat;
    snes_banked_t banked;
  } snes_addr_u;

endpackage

/* snes_bus_sync.sv */
`timescale 1ns/1ns

module snes_bus_sync import cart_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [23:0] snes_addr,
  input  logic [7:0]  snes_pa,
  input  logic        snes_romsel,
  input  logic        snes_rd,
  input  logic        snes_wr,
  output snes_addr_u  addr,
  output logic [7:0]  pa,
  output logic        romsel,
  output logic        rd_start,
  output logic        wr_end
);

  logic rd_meta;
  logic rd_sync;
  logic rd_last;
  logic wr_meta;
  logic wr_sync;
  logic wr_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      addr.flat <= 24'h000000;
      pa        <= 8'h00;
      romsel    <= 1'b1;  // ROM deselected
    end else begin
      addr.flat <= snes_addr;
      pa        <= snes_pa;
      romsel    <= snes_romsel;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_meta  <= 1'b1;  // Strobes idle high
      rd_sync  <= 1'b1;
      rd_last  <= 1'b1;
      wr_meta  <= 1'b1;
      wr_sync  <= 1'b1;
      wr_last  <= 1'b1;
      rd_start <= 1'b0;
      wr_end   <= 1'b0;
    end else begin
      rd_meta  <= snes_rd;
      rd_sync  <= rd_meta;
      rd_last  <= rd_sync;
      wr_meta  <= snes_wr;
      wr_sync  <= wr_meta;
      wr_last  <= wr_sync;
      rd_start <= rd_last & ~rd_sync;  // Falling edge of /RD
      wr_end   <= ~wr_last & wr_sync;  // Rising edge of /WR
    end
  end

endmodule

/* cart_config.sv */
`timescale 1ns/1ns

`include "cart_settings.svh"

module cart_config (
  input  logic        clk,
  input  logic        reset,
  input  logic        cfg_we,
  input  logic [3:0]  cfg_sel,
  input  logic [7:0]  cfg_data,
  output logic [2:0]  mapper,
  output logic [15:0] featurebits,
  output logic [23:0] rom_mask,
  output logic [23:0] saveram_mask
);

  always_ff @(posedge clk) begin
    if (reset) begin
      mapper       <= 3'd0;
      featurebits  <= 16'h0000;
      rom_mask     <= 24'h000000;
      saveram_mask <= 24'h000000;  // Save RAM off until mask is loaded
    end else if (cfg_we) begin
      case (cfg_sel)
        `CFG_MAPPER: begin
          mapper <= cfg_data[2:0];
        end
        `CFG_FEAT_LO: begin
          featurebits[7:0] <= cfg_data;
        end
        `CFG_FEAT_HI: begin
          featurebits[15:8] <= cfg_data;
        end
        `CFG_ROMMASK_0: begin
          rom_mask[7:0] <= cfg_data;
        end
        `CFG_ROMMASK_1: begin
          rom_mask[15:8] <= cfg_data;
        end
        `CFG_ROMMASK_2: begin
          rom_mask[23:16] <= cfg_data;
        end
        `CFG_SRAMMASK_0: begin
          saveram_mask[7:0] <= cfg_data;
        end
        `CFG_SRAMMASK_1: begin
          saveram_mask[15:8] <= cfg_data;
        end
        `CFG_SRAMMASK_2: begin
          saveram_mask[23:16] <= cfg_data;
        end
        default: begin
          // Unknown selector, nothing written
        end
      endcase
    end
  end

endmodule

/* address_decode.sv */
`timescale 1ns/1ns

`include "cart_settings.svh"

module address_decode import cart_pkg::*; (
  input  snes_addr_u  addr,
  input  logic [7:0]  pa,
  input  logic        romsel,
  input  logic [2:0]  mapper,
  input  logic [15:0] featurebits,
  input  logic [23:0] rom_mask,
  input  logic [23:0] saveram_mask,
  output logic [23:0] rom_addr,
  output logic        rom_hit,
  output logic        is_rom,
  output logic        is_saveram,
  output logic        msu_enable,
  output logic        r213f_enable,
  output logic        r2100_hit,
  output logic        snescmd_enable,
  output logic        nmicmd_enable,
  output logic        return_vector_enable,
  output logic        branch1_enable,
  output logic        branch2_enable,
  output logic        branch3_enable
);

  logic [23:0] a;
  logic [7:0]  bank;
  logic        a15;
  logic [14:0] ofs;
  logic        st0010_win;
  logic        map_sram;
  logic [14:0] map6_sram_ofs;

  assign a    = addr.flat;
  assign bank = addr.banked.bank;
  assign a15  = addr.banked.a15;
  assign ofs  = addr.banked.offset;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Save RAM window
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign st0010_win = (a[22:19] == 4'b1101) & (a[15:12] == 4'b0000) & a[11];

  always_comb begin
    case (mapper)
      `MAPPER_LOROM, `MAPPER_EXHIROM, `MAPPER_MAP6: begin
        map_sram = ~bank[6] & bank[5] & (&ofs[14:13]) & ~a15;
      end
      `MAPPER_SDD1: begin
        map_sram = (a[23:19] == 5'b01110) & (a[15:13] == 3'b011);
      end
      `MAPPER_HIROM: begin
        map_sram = (&a[22:20]) & ~romsel & (~a[15] | ~rom_mask[21]);
      end
      `MAPPER_MAP3: begin
        map_sram = (a[23:19] == 5'b00010) & (a[15:12] == 4'b0101);
      end
      `MAPPER_MAP7: begin
        map_sram = &a[23:20];
      end
      default: begin
        map_sram = 1'b0;
      end
    endcase
  end

  // ST0010 window takes priority over the mapper
  assign is_saveram = saveram_mask[0] & (featurebits[`FEAT_ST0010] ? st0010_win : map_sram);
  assign is_rom     = ~romsel;
  assign rom_hit    = is_rom | is_saveram;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory address per mapper
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign map6_sram_ofs = ofs - 15'h6000;  // Window starts at x:6000

  always_comb begin
    case (mapper)
      `MAPPER_LOROM: begin
        if (is_saveram) begin
          rom_addr = `SAVERAM_BASE + ({6'b0, bank[4:0], ofs[12:0]} & saveram_mask);
        end else begin
          rom_addr = {1'b0, a[22:0]} & rom_mask;
        end
      end
      `MAPPER_HIROM: begin
        if (is_saveram) begin
          rom_addr = `SAVERAM_BASE + ({4'b0, a[20:16], a[14:0]} & saveram_mask);
        end else begin
          rom_addr = {1'b0, ~a[23], a[22:16], a[14:0]} & rom_mask;
        end
      end
      `MAPPER_EXHIROM, `MAPPER_SDD1: begin
        if (is_saveram) begin
          rom_addr = `SAVERAM_BASE + ({7'b0, a[19:16], a[12:0]} & saveram_mask);
        end else begin
          rom_addr = {1'b0, ~a[23], a[21:0]} & rom_mask;
        end
      end
      `MAPPER_MAP6: begin
        if (is_saveram) begin
          rom_addr = `SAVERAM_BASE + ({9'b0, map6_sram_ofs} & saveram_mask);
        end else if (a15) begin
          rom_addr = {1'b0, bank, ofs};  // Upper half passes through
        end else begin
          rom_addr = {2'b10, bank[7], bank[5:0], ofs};
        end
      end
      `MAPPER_MAP7: begin
        if (is_saveram) begin
          rom_addr = a;
        end else begin
          rom_addr = ({1'b0, a[22:0]} & rom_mask) + 24'hC00000;
        end
      end
      default: begin
        rom_addr = 24'h000000;
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Special regions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign msu_enable = featurebits[`FEAT_MSU1] & ~a[22]
                    & ((a[15:0] & 16'hFFF8) == `MSU_BASE);  // 8 regs at 2000

  assign r213f_enable = featurebits[`FEAT_213F] & (pa == 8'h3F);
  assign r2100_hit    = (pa == 8'h00);

  assign snescmd_enable = ({a[22], a[15:9]} == 8'b0_0010101);  // 2A00-2BFF

  // Hook points, exact match
  assign nmicmd_enable        = (a == 24'h002BF2);
  assign return_vector_enable = (a == 24'h002A6C);
  assign branch1_enable       = (a == 24'h002A1F);
  assign branch2_enable       = (a == 24'h002A59);
  assign branch3_enable       = (a == 24'h002A5E);

endmodule

/* msu_regs.sv */
`timescale 1ns/1ns

`include "cart_settings.svh"

module msu_regs (
  input  logic        clk,
  input  logic        reset,
  input  logic        msu_enable,
  input  logic [2:0]  offset,
  input  logic [7:0]  wdata,
  input  logic        rd_start,
  input  logic        wr_end,
  input  logic [7:0]  msu_status,
  output logic [7:0]  msu_rdata,
  output logic [31:0] msu_seek_addr,
  output logic [15:0] msu_track,
  output logic [7:0]  msu_volume,
  output logic [7:0]  msu_ctrl,
  output logic        msu_seek_start,
  output logic        msu_track_start
);

  logic       wr_take;
  logic [7:0] rd_mux;

  assign wr_take = wr_end & msu_enable;

  always_ff @(posedge clk) begin
    if (reset) begin
      msu_seek_addr   <= 32'h0000_0000;
      msu_track       <= 16'h0000;
      msu_volume      <= 8'h00;
      msu_ctrl        <= 8'h00;
      msu_seek_start  <= 1'b0;
      msu_track_start <= 1'b0;
    end else begin
      msu_seek_start  <= wr_take & (offset == `MSU_OFS_SEEK_3);  // Top byte starts seek
      msu_track_start <= wr_take & (offset == `MSU_OFS_TRK_HI);
      if (wr_take) begin
        case (offset)
          `MSU_OFS_SEEK_0: msu_seek_addr[7:0]   <= wdata;
          `MSU_OFS_SEEK_1: msu_seek_addr[15:8]  <= wdata;
          `MSU_OFS_SEEK_2: msu_seek_addr[23:16] <= wdata;
          `MSU_OFS_SEEK_3: msu_seek_addr[31:24] <= wdata;
          `MSU_OFS_TRK_LO: msu_track[7:0]       <= wdata;
          `MSU_OFS_TRK_HI: msu_track[15:8]      <= wdata;
          `MSU_OFS_VOLUME: msu_volume           <= wdata;
          default:         msu_ctrl             <= wdata;
        endcase
      end
    end
  end

  // ID string "S-MSU1" at offsets 2..7
  always_comb begin
    case (offset)
      3'd0:    rd_mux = msu_status;
      3'd1:    rd_mux = 8'h00;
      3'd2:    rd_mux = "S";
      3'd3:    rd_mux = "-";
      3'd4:    rd_mux = "M";
      3'd5:    rd_mux = "S";
      3'd6:    rd_mux = "U";
      default: rd_mux = "1";
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      msu_rdata <= 8'h00;
    end else if (rd_start && msu_enable) begin
      msu_rdata <= rd_mux;  // Held until next read
    end
  end

endmodule

/* cart_top.sv */
`timescale 1ns/1ns

module cart_top import cart_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [23:0] snes_addr,
  input  logic [7:0]  snes_pa,
  input  logic        snes_romsel,
  input  logic        snes_rd,
  input  logic        snes_wr,
  input  logic [7:0]  snes_data,
  input  logic        cfg_we,
  input  logic [3:0]  cfg_sel,
  input  logic [7:0]  cfg_data,
  input  logic [7:0]  msu_status,
  output logic [23:0] rom_addr,
  output logic        rom_hit,
  output logic        is_rom,
  output logic        is_saveram,
  output logic        msu_enable,
  output logic        r213f_enable,
  output logic        r2100_hit,
  output logic        snescmd_enable,
  output logic        nmicmd_enable,
  output logic        return_vector_enable,
  output logic        branch1_enable,
  output logic        branch2_enable,
  output logic        branch3_enable,
  output logic [7:0]  msu_rdata,
  output logic [31:0] msu_seek_addr,
  output logic [15:0] msu_track,
  output logic [7:0]  msu_volume,
  output logic [7:0]  msu_ctrl,
  output logic        msu_seek_start,
  output logic        msu_track_start
);

  snes_addr_u  addr;
  logic [7:0]  pa;
  logic        romsel;
  logic        rd_start;
  logic        wr_end;
  logic [2:0]  mapper;
  logic [15:0] featurebits;
  logic [23:0] rom_mask;
  logic [23:0] saveram_mask;

  snes_bus_sync snes_bus_sync_inst (
    .clk         (clk),
    .reset       (reset),
    .snes_addr   (snes_addr),
    .snes_pa     (snes_pa),
    .snes_romsel (snes_romsel),
    .snes_rd     (snes_rd),
    .snes_wr     (snes_wr),
    .addr        (addr),
    .pa          (pa),
    .romsel      (romsel),
    .rd_start    (rd_start),
    .wr_end      (wr_end)
  );

  cart_config cart_config_inst (
    .clk          (clk),
    .reset        (reset),
    .cfg_we       (cfg_we),
    .cfg_sel      (cfg_sel),
    .cfg_data     (cfg_data),
    .mapper       (mapper),
    .featurebits  (featurebits),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask)
  );

  address_decode address_decode_inst (
    .addr                 (addr),
    .pa                   (pa),
    .romsel               (romsel),
    .mapper               (mapper),
    .featurebits          (featurebits),
    .rom_mask             (rom_mask),
    .saveram_mask         (saveram_mask),
    .rom_addr             (rom_addr),
    .rom_hit              (rom_hit),
    .is_rom               (is_rom),
    .is_saveram           (is_saveram),
    .msu_enable           (msu_enable),
    .r213f_enable         (r213f_enable),
    .r2100_hit            (r2100_hit),
    .snescmd_enable       (snescmd_enable),
    .nmicmd_enable        (nmicmd_enable),
    .return_vector_enable (return_vector_enable),
    .branch1_enable       (branch1_enable),
    .branch2_enable       (branch2_enable),
    .branch3_enable       (branch3_enable)
  );

  msu_regs msu_regs_inst (
    .clk             (clk),
    .reset           (reset),
    .msu_enable      (msu_enable),
    .offset          (addr.flat[2:0]),  // Register index from low address bits
    .wdata           (snes_data),
    .rd_start        (rd_start),
    .wr_end          (wr_end),
    .msu_status      (msu_status),
    .msu_rdata       (msu_rdata),
    .msu_seek_addr   (msu_seek_addr),
    .msu_track       (msu_track),
    .msu_volume      (msu_volume),
    .msu_ctrl        (msu_ctrl),
    .msu_seek_start  (msu_seek_start),
    .msu_track_start (msu_track_start)
  );

endmodule

/* cart_props.sv */
`timescale 1ns/1ns

`include "cart_settings.svh"

module cart_props (
  input logic       clk,
  input logic       reset,
  input logic       rd_start,
  input logic       wr_end,
  input logic       cfg_we,
  input logic [3:0] cfg_sel,
  input logic       is_saveram,
  input logic       nmicmd_enable,
  input logic       return_vector_enable,
  input logic       branch1_enable,
  input logic       branch2_enable,
  input logic       branch3_enable
);

  logic sram_mask_seen;

  always_ff @(posedge clk) begin
    if (reset) begin
      sram_mask_seen <= 1'b0;
    end else if (cfg_we && (cfg_sel == `CFG_SRAMMASK_0 || cfg_sel == `CFG_SRAMMASK_1
                            || cfg_sel == `CFG_SRAMMASK_2)) begin
      sram_mask_seen <= 1'b1;
    end
  end

  rd_single: assert property (@(posedge clk) disable iff (reset) rd_start |=> !rd_start)
    else $error("rd_start high for two cycles");

  wr_single: assert property (@(posedge clk) disable iff (reset) wr_end |=> !wr_end)
    else $error("wr_end high for two cycles");

  sram_quiet: assert property (@(posedge clk) disable iff (reset)
                               !sram_mask_seen |-> !is_saveram)
    else $error("is_saveram high before any save RAM mask write");

  hooks_excl: assert property (@(posedge clk) disable iff (reset)
      $onehot0({nmicmd_enable, return_vector_enable, branch1_enable, branch2_enable,
                branch3_enable}))
    else $error("more than one hook enable active");

endmodule

bind cart_top cart_props cart_props_inst (
  .clk                  (clk),
  .reset                (reset),
  .rd_start             (rd_start),
  .wr_end               (wr_end),
  .cfg_we               (cfg_we),
  .cfg_sel              (cfg_sel),
  .is_saveram           (is_saveram),
  .nmicmd_enable        (nmicmd_enable),
  .return_vector_enable (return_vector_enable),
  .branch1_enable       (branch1_enable),
  .branch2_enable       (branch2_enable),
  .branch3_enable       (branch3_enable)
);

/* cart_tb.sv */
`timescale 1ns/1ns

`include "cart_settings.svh"

module cart_tb import cart_pkg::*; ();

  logic        clk;
  logic        reset;
  logic [23:0] snes_addr;
  logic [7:0]  snes_pa;
  logic        snes_romsel;
  logic        snes_rd;
  logic        snes_wr;
  logic [7:0]  snes_data;
  logic        cfg_we;
  logic [3:0]  cfg_sel;
  logic [7:0]  cfg_data;
  logic [7:0]  msu_status;
  logic [23:0] rom_addr;
  logic        rom_hit;
  logic        is_rom;
  logic        is_saveram;
  logic        msu_enable;
  logic        r213f_enable;
  logic        r2100_hit;
  logic        snescmd_enable;
  logic        nmicmd_enable;
  logic        return_vector_enable;
  logic        branch1_enable;
  logic        branch2_enable;
  logic        branch3_enable;
  logic [7:0]  msu_rdata;
  logic [31:0] msu_seek_addr;
  logic [15:0] msu_track;
  logic [7:0]  msu_volume;
  logic [7:0]  msu_ctrl;
  logic        msu_seek_start;
  logic        msu_track_start;

  int          errors = 0;
  int          checks = 0;
  int          seek_pulses = 0;
  int          track_pulses = 0;
  logic [31:0] seed = 32'hf6f1_763a;

  cart_top cart_top_inst (.*);

  always #2 clk = ~clk;  // 4 ns period

  always @(negedge clk) begin
    if (msu_seek_start) seek_pulses++;
    if (msu_track_start) track_pulses++;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks and helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic compare_addr(input snes_addr_u got, input snes_addr_u exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t ns: %s got %06h expected %06h", $time, msg, got.flat, exp.flat);
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t ns: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t ns: %s got %02h expected %02h", $time, msg, got, exp);
    end
  endtask

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic snes_addr_u make_addr(input logic [7:0] bank, input logic [15:0] ofs);
    snes_addr_u u;
    u.banked.bank   = bank;
    u.banked.a15    = ofs[15];
    u.banked.offset = ofs[14:0];
    return u;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_pulses(input int seek_exp, input int track_exp);
    int n;
    n = 0;
    while ((seek_pulses < seek_exp || track_pulses < track_exp) && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (seek_pulses < seek_exp || track_pulses < track_exp) begin
      errors++;
      $display("timeout waiting for the MSU seek and track start pulses");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus and config tasks called right after a falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic config_write(input logic [3:0] sel, input logic [7:0] data);
    cfg_we   = 1'b1;
    cfg_sel  = sel;
    cfg_data = data;
    wait_cycles(1);
    cfg_we   = 1'b0;  // Taken on the rising edge in between
  endtask

  task automatic load_masks(input logic [23:0] rmask, input logic [23:0] smask);
    config_write(`CFG_ROMMASK_0, rmask[7:0]);
    config_write(`CFG_ROMMASK_1, rmask[15:8]);
    config_write(`CFG_ROMMASK_2, rmask[23:16]);
    config_write(`CFG_SRAMMASK_0, smask[7:0]);
    config_write(`CFG_SRAMMASK_1, smask[15:8]);
    config_write(`CFG_SRAMMASK_2, smask[23:16]);
  endtask

  task automatic apply_addr(input snes_addr_u a, input logic romsel);
    snes_addr   = a.flat;
    snes_romsel = romsel;
    wait_cycles(2);  // Registered, then decoded
  endtask

  task automatic bus_write(input snes_addr_u a, input logic [7:0] data);
    snes_addr   = a.flat;
    snes_romsel = 1'b1;
    snes_data   = data;
    snes_wr     = 1'b0;
    wait_cycles(5);
    snes_wr     = 1'b1;
    wait_cycles(5);  // Sync plus register stage
  endtask

  task automatic bus_read(input snes_addr_u a, output logic [7:0] data);
    snes_addr   = a.flat;
    snes_romsel = 1'b1;
    snes_rd     = 1'b0;
    wait_cycles(5);
    snes_rd     = 1'b1;
    wait_cycles(2);
    data        = msu_rdata;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic reset_decode_zero();
    logic [31:0] r;
    snes_addr_u  a;
    for (int i = 0; i < 16; i++) begin
      r = lcg_next();
      a.flat = r[23:0];
      apply_addr(a, r[24]);
      compare_addr(rom_addr, {1'b0, a.flat[22:0]} & 24'h000000, "reset rom_addr");
      compare_flag(is_saveram, 1'b0, $sformatf("reset is_saveram at %06h", a.flat));
      compare_flag(msu_enable, 1'b0, $sformatf("reset msu_enable at %06h", a.flat));
      compare_flag(is_rom, ~r[24], "is_rom follows romsel");
    end
  endtask

  task automatic lorom_random_decode();
    logic [31:0] r;
    snes_addr_u  a;
    logic        sram;
    config_write(`CFG_MAPPER, `MAPPER_LOROM);
    load_masks(24'hFFFFFF, 24'hFFFFFF);
    for (int i = 0; i < 32; i++) begin
      r = lcg_next();
      a.flat = r[23:0];
      if (i % 2 == 1) begin  // Force into the save RAM window
        a.banked.bank[6]       = 1'b0;
        a.banked.bank[5]       = 1'b1;
        a.banked.a15           = 1'b0;
        a.banked.offset[14:13] = 2'b11;
      end
      sram = ~a.flat[22] & a.flat[21] & a.flat[14] & a.flat[13] & ~a.flat[15];
      apply_addr(a, r[25]);
      compare_flag(is_saveram, sram, $sformatf("lorom is_saveram at %06h", a.flat));
      compare_flag(rom_hit, ~r[25] | sram, $sformatf("lorom rom_hit at %06h", a.flat));
      if (sram) begin
        compare_addr(rom_addr, `SAVERAM_BASE + {6'b0, a.flat[20:16], a.flat[12:0]},
                     $sformatf("lorom save ram addr at %06h", a.flat));
      end else begin
        compare_addr(rom_addr, {1'b0, a.flat[22:0]}, $sformatf("lorom rom addr at %06h", a.flat));
      end
    end
  endtask

  task automatic hirom_map7_windows();
    config_write(`CFG_MAPPER, `MAPPER_HIROM);
    apply_addr(make_addr(8'h70, 16'h6123), 1'b0);
    compare_flag(is_saveram, 1'b1, "hirom save ram low half");
    compare_addr(rom_addr, 24'hE86123, "hirom save ram addr");
    apply_addr(make_addr(8'h70, 16'hE123), 1'b0);
    compare_flag(is_saveram, 1'b0, "hirom upper half with rom_mask bit 21");
    compare_addr(rom_addr, 24'h786123, "hirom rom addr");
    config_write(`CFG_ROMMASK_2, 8'hDF);
    compare_flag(is_saveram, 1'b1, "hirom upper half without rom_mask bit 21");
    compare_addr(rom_addr, 24'hE86123, "hirom save ram addr upper half");
    apply_addr(make_addr(8'hC0, 16'h1234), 1'b0);
    compare_addr(rom_addr, 24'h001234, "hirom rom addr masked");
    config_write(`CFG_ROMMASK_2, 8'hFF);
    config_write(`CFG_MAPPER, `MAPPER_MAP7);
    apply_addr(make_addr(8'hF0, 16'h1234), 1'b0);
    compare_flag(is_saveram, 1'b1, "map7 save ram");
    compare_addr(rom_addr, 24'hF01234, "map7 save ram addr");
    apply_addr(make_addr(8'h12, 16'h3456), 1'b0);
    compare_flag(is_saveram, 1'b0, "map7 rom");
    compare_addr(rom_addr, 24'hD23456, "map7 rom addr");
  endtask

  task automatic feature_enables();
    config_write(`CFG_MAPPER, `MAPPER_LOROM);
    config_write(`CFG_FEAT_LO, 8'h00);
    snes_pa = 8'h3F;
    apply_addr(make_addr(8'h00, 16'h2003), 1'b1);
    compare_flag(msu_enable, 1'b0, "msu_enable with feature off");
    compare_flag(r213f_enable, 1'b0, "r213f_enable with feature off");
    compare_flag(r2100_hit, 1'b0, "r2100_hit with pa 3f");
    config_write(`CFG_FEAT_LO, 8'h18);  // MSU1 and 213F
    compare_flag(msu_enable, 1'b1, "msu_enable with feature on");
    compare_flag(r213f_enable, 1'b1, "r213f_enable with feature on");
    apply_addr(make_addr(8'h40, 16'h2003), 1'b1);
    compare_flag(msu_enable, 1'b0, "msu_enable with bit 22 set");
    apply_addr(make_addr(8'h00, 16'h2008), 1'b1);
    compare_flag(msu_enable, 1'b0, "msu_enable past 2007");
    config_write(`CFG_FEAT_LO, 8'h00);
    snes_pa = 8'h00;
    wait_cycles(2);
    compare_flag(r2100_hit, 1'b1, "r2100_hit with features off");
    compare_flag(r213f_enable, 1'b0, "r213f_enable with pa 00");
    config_write(`CFG_FEAT_LO, 8'h02);  // ST0010
    apply_addr(make_addr(8'h68, 16'h0800), 1'b0);
    compare_flag(is_saveram, 1'b1, "st0010 window");
    apply_addr(make_addr(8'h30, 16'h6000), 1'b0);
    compare_flag(is_saveram, 1'b0, "lorom window under st0010");
    config_write(`CFG_FEAT_LO, 8'h00);
    compare_flag(is_saveram, 1'b1, "lorom window without st0010");
  endtask

  task automatic msu_register_access();
    logic [7:0] wdat [8] = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66, 8'h77, 8'h88};
    logic [7:0] rexp [8] = '{8'h5A, 8'h00, "S", "-", "M", "S", "U", "1"};
    logic [7:0] rd;
    config_write(`CFG_FEAT_LO, 8'h08);
    msu_status = 8'h5A;
    for (int i = 0; i < 8; i++) begin
      bus_write(make_addr(8'h00, `MSU_BASE + 16'(i)), wdat[i]);
    end
    wait_pulses(1, 1);
    compare_flag(seek_pulses == 1, 1'b1, "one seek start pulse");
    compare_flag(track_pulses == 1, 1'b1, "one track start pulse");
    for (int i = 0; i < 4; i++) begin
      compare_byte(msu_seek_addr[8*i +: 8], wdat[i], $sformatf("seek byte %0d", i));
    end
    compare_byte(msu_track[7:0], wdat[4], "track low");
    compare_byte(msu_track[15:8], wdat[5], "track high");
    compare_byte(msu_volume, wdat[6], "volume");
    compare_byte(msu_ctrl, wdat[7], "control");
    for (int i = 0; i < 8; i++) begin
      bus_read(make_addr(8'h00, `MSU_BASE + 16'(i)), rd);
      compare_byte(rd, rexp[i], $sformatf("msu read offset %0d", i));
    end
  endtask

  task automatic hook_enables();
    logic [23:0] hooks [5] = '{24'h002BF2, 24'h002A6C, 24'h002A1F, 24'h002A59, 24'h002A5E};
    logic [23:0] cmd_in [3] = '{24'h002A00, 24'h002BFF, 24'h802A00};
    logic [23:0] cmd_out [3] = '{24'h402A00, 24'h0029FF, 24'h002C00};
    logic [4:0]  got;
    for (int i = 0; i < 5; i++) begin
      apply_addr(make_addr(hooks[i][23:16], hooks[i][15:0]), 1'b1);
      got = {branch3_enable, branch2_enable, branch1_enable, return_vector_enable,
             nmicmd_enable};
      for (int k = 0; k < 5; k++) begin
        compare_flag(got[k], k == i, $sformatf("hook %06h enable %0d", hooks[i], k));
      end
    end
    for (int i = 0; i < 3; i++) begin
      apply_addr(make_addr(cmd_in[i][23:16], cmd_in[i][15:0]), 1'b1);
      compare_flag(snescmd_enable, 1'b1, $sformatf("snescmd at %06h", cmd_in[i]));
      apply_addr(make_addr(cmd_out[i][23:16], cmd_out[i][15:0]), 1'b1);
      compare_flag(snescmd_enable, 1'b0, $sformatf("snescmd at %06h", cmd_out[i]));
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    snes_addr   = 24'h000000;
    snes_pa     = 8'hFF;
    snes_romsel = 1'b1;
    snes_rd     = 1'b1;
    snes_wr     = 1'b1;
    snes_data   = 8'h00;
    cfg_we      = 1'b0;
    cfg_sel     = 4'h0;
    cfg_data    = 8'h00;
    msu_status  = 8'h00;
    wait_cycles(4);
    reset = 1'b0;
    reset_decode_zero();
    lorom_random_decode();
    hirom_map7_windows();
    feature_enables();
    msu_register_access();
    hook_enables();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* cart.f */
+incdir+.
cart_pkg.sv
snes_bus_sync.sv
cart_config.sv
address_decode.sv
msu_regs.sv
cart_top.sv
cart_props.sv
cart_tb.sv

/* Bender.yml */
package:
  name: cart

sources:
  - include_dirs:
      - .
    files:
      - cart_pkg.sv
      - snes_bus_sync.sv
      - cart_config.sv
      - address_decode.sv
      - msu_regs.sv
      - cart_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - cart_props.sv
      - cart_tb.sv
